// File: flist.f
+incdir+tests
rtl/dasm_pkg.sv
rtl/dasm_decode.sv
rtl/dasm_execute.sv
rtl/dasm_result.sv
rtl/dasm_top.sv
tests/tb_dasm.sv

// File: rtl/dasm_decode.sv
// Decode stage; one cycle, accepts a word every clock, anything outside the kept classes is UNDEF
`timescale 1ns/1ps
`default_nettype none

module dasm_decode (
        input  wire logic               i_clk,
        input  wire logic               i_arst_n,
        input  wire logic               i_valid,
        input  wire dasm_pkg::insn_u    i_instruction,
        output      logic               o_valid,
        output      dasm_pkg::decoded_t o_dec
);

        dasm_pkg::dp_fields_t  dp;
        dasm_pkg::br_fields_t  br;
        dasm_pkg::insn_class_e cls;
        dasm_pkg::decoded_t    dec;
        logic                  psr_grp;         // Bits 27..23 = 00010, S clear
        logic                  cmp_no_s;        // TST..CMN without S

        assign dp = i_instruction.dp;
        assign br = i_instruction.br;

        assign psr_grp  = ({dp.cls, dp.opcode[3:2]} == 5'b00010) && !dp.s;
        assign cmp_no_s = (dp.opcode[3:2] == 2'b10) && !dp.s;

        // ------------------------------------------------------------
        // Classification, first match wins
        // ------------------------------------------------------------
        always_comb
        begin
                if (psr_grp && !dp.opcode[0] && dp.rn == 4'hF && dp.op2 == 12'h000)
                        cls = dasm_pkg::CLS_MRS;
                else if (psr_grp && dp.opcode[0] && dp.rd == 4'hF && dp.op2[11:4] == 8'h00)
                        cls = dasm_pkg::CLS_MSR;
                else if (br.cls == 3'b111 && br.link)
                        cls = dasm_pkg::CLS_SWI;
                else if (br.cls == 3'b101)
                        cls = dasm_pkg::CLS_BRANCH;
                else if (cmp_no_s)
                        cls = dasm_pkg::CLS_UNDEF;      // Would alias MRS/MSR space
                else if (dp.cls == 3'b001)
                        cls = dasm_pkg::CLS_DP_IMM;
                else if (dp.cls == 3'b000 && !dp.op2[4])
                        cls = dasm_pkg::CLS_DP_ISS;
                else if (dp.cls == 3'b000 && !dp.op2[7])
                        cls = dasm_pkg::CLS_DP_RSS;
                else
                        cls = dasm_pkg::CLS_UNDEF;      // Multiplies, loads, coprocessor
        end

        // Field extraction, every view read regardless of class
        always_comb
        begin
                dec.cls     = cls;
                dec.cond    = dp.cond;
                dec.opcode  = dp.opcode;
                dec.rd      = dp.rd;
                dec.rn      = dp.rn;
                dec.rm      = dp.op2[3:0];
                dec.rs      = dp.op2[11:8];
                dec.sh_type = dp.op2[6:5];
                dec.sh_amt  = dp.op2[11:7];
                dec.imm8    = dp.op2[7:0];
                dec.rot     = dp.op2[11:8];
                dec.link    = br.link;
                dec.spsr    = dp.opcode[1];     // Bit 22
                dec.imm24   = br.imm24;
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                        o_valid <= 1'b0;
                else
                        o_valid <= i_valid;
        end

        always_ff @(posedge i_clk)
        begin
                o_dec <= dec;
        end

        // A valid decode always carries a known class downstream
        a_cls_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> !$isunknown(o_dec.cls));

endmodule

`default_nettype wire

// File: rtl/dasm_execute.sv
// Execute stage; one cycle, turns fields into ASCII tokens, numbers print as uppercase hex
`timescale 1ns/1ps
`default_nettype none

module dasm_execute (
        input  wire logic               i_clk,
        input  wire logic               i_arst_n,
        input  wire logic               i_valid,
        input  wire dasm_pkg::decoded_t i_dec,
        output      logic               o_valid,
        output      dasm_pkg::tokens_t  o_tok
);

        dasm_pkg::tokens_t tok;
        logic [7:0]        hex2_val;

        // ------------------------------------------------------------
        // Token helpers
        // ------------------------------------------------------------
        function automatic logic [7:0] hex_char(input logic [3:0] d);
                hex_char = (d < 4'd10) ? 8'h30 + {4'h0, d} : 8'h37 + {4'h0, d};
        endfunction

        function automatic dasm_pkg::token_t reg_tok(input logic [3:0] r);
                dasm_pkg::token_t t;
                t     = dasm_pkg::TOK_NONE;
                t.len = 3'd2;
                case (r)
                4'd13:   t.chars[0:1] = "SP";
                4'd14:   t.chars[0:1] = "LR";
                4'd15:   t.chars[0:1] = "PC";
                4'd10, 4'd11, 4'd12:
                begin
                        t.chars[0:2] = {"R1", 8'h30 + {4'h0, r} - 8'd10};
                        t.len        = 3'd3;
                end
                default: t.chars[0:1] = {"R", hex_char(r)};
                endcase
                return t;
        endfunction

        // Base of 1..3 letters followed by the condition suffix
        function automatic dasm_pkg::token_t mnem_tok(input logic [0:2][7:0] base,
                                                      input logic [2:0]       blen,
                                                      input logic [3:0]       cond);
                dasm_pkg::token_t t;
                t                 = dasm_pkg::TOK_NONE;
                t.chars[0:2]      = base;
                t.chars[blen +: 2] = dasm_pkg::COND_NAMES[cond];
                t.len             = blen + 3'd2;
                return t;
        endfunction

        // ------------------------------------------------------------
        // Token build
        // ------------------------------------------------------------
        assign hex2_val = (i_dec.cls == dasm_pkg::CLS_DP_IMM) ? i_dec.imm8 : {3'b000, i_dec.sh_amt};

        always_comb
        begin
                tok.cls = i_dec.cls;
                case (i_dec.cls)
                dasm_pkg::CLS_DP_IMM, dasm_pkg::CLS_DP_ISS, dasm_pkg::CLS_DP_RSS:
                        tok.mnem = mnem_tok(dasm_pkg::OPCODE_NAMES[i_dec.opcode], 3'd3, i_dec.cond);
                dasm_pkg::CLS_BRANCH:
                        tok.mnem = i_dec.link ? mnem_tok("BL ", 3'd2, i_dec.cond)
                                              : mnem_tok("B  ", 3'd1, i_dec.cond);
                dasm_pkg::CLS_SWI: tok.mnem = mnem_tok("SWI", 3'd3, i_dec.cond);
                dasm_pkg::CLS_MRS: tok.mnem = mnem_tok("MRS", 3'd3, i_dec.cond);
                dasm_pkg::CLS_MSR: tok.mnem = mnem_tok("MSR", 3'd3, i_dec.cond);
                default:           tok.mnem = dasm_pkg::TOK_NONE;  // Result prints UNDEFINED
                endcase

                tok.rd = reg_tok(i_dec.rd);
                tok.rn = reg_tok(i_dec.rn);
                tok.rm = reg_tok(i_dec.rm);
                tok.rs = reg_tok(i_dec.rs);

                tok.shift = dasm_pkg::TOK_NONE;
                if (i_dec.cls == dasm_pkg::CLS_MRS || i_dec.cls == dasm_pkg::CLS_MSR)
                begin
                        tok.shift.chars[0:3] = i_dec.spsr ? "SPSR" : "CPSR";
                        tok.shift.len        = 3'd4;
                end
                else
                begin
                        tok.shift.chars[0:2] = dasm_pkg::SHIFT_NAMES[i_dec.sh_type];
                        tok.shift.len        = 3'd3;
                end

                tok.hex2          = dasm_pkg::TOK_NONE;
                tok.hex2.chars[0] = hex_char(hex2_val[7:4]);
                tok.hex2.chars[1] = hex_char(hex2_val[3:0]);
                tok.hex2.len      = 3'd2;

                tok.hex1          = dasm_pkg::TOK_NONE;
                tok.hex1.chars[0] = hex_char(i_dec.rot);
                tok.hex1.len      = 3'd1;

                tok.hex6 = dasm_pkg::TOK_NONE;
                for (int i = 0; i < dasm_pkg::TOKEN_CHARS; i++)
                begin
                        tok.hex6.chars[i] = hex_char(i_dec.imm24[23 - 4*i -: 4]);
                end
                tok.hex6.len = 3'd6;
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                        o_valid <= 1'b0;
                else
                        o_valid <= i_valid;
        end

        always_ff @(posedge i_clk)
        begin
                o_tok <= tok;
        end

        // No token may spill past its slot into the next one in result
        a_tok_len: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> (o_tok.mnem.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.rd.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.rn.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.rm.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.rs.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.shift.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.hex2.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.hex1.len <= dasm_pkg::TOKEN_CHARS) &&
                            (o_tok.hex6.len <= dasm_pkg::TOKEN_CHARS));

endmodule

`default_nettype wire

// File: rtl/dasm_pkg.sv
// Shared types for the ARM disassembler; only DP, branch, SWI, MRS and MSR register form decode
`default_nettype none

package dasm_pkg;

        // ------------------------------------------------------------
        // Sizes
        // ------------------------------------------------------------
        localparam int INSN_BITS   = 32;
        localparam int TEXT_CHARS  = 32;        // Output line width
        localparam int TOKEN_CHARS = 6;         // Widest token, hex6
        localparam int SEQ_TOKENS  = 11;        // Most tokens any line needs

        // Name tables, entry 0 leftmost
        localparam logic [0:15][0:1][7:0] COND_NAMES =
                "EQNECSCCMIPLVSVCHILSGELTGTLEALNV";
        localparam logic [0:15][0:2][7:0] OPCODE_NAMES =
                "ANDEORSUBRSBADDADCSBCRSCTSTTEQCMPCMNORRMOVBICMVN";
        localparam logic [0:3][0:2][7:0] SHIFT_NAMES = "LSLLSRASRROR";

        // ------------------------------------------------------------
        // Instruction word views
        // ------------------------------------------------------------
        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  cls;               // Bits 27..25
                logic [3:0]  opcode;
                logic        s;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] op2;
        } dp_fields_t;

        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  cls;
                logic        link;              // Bit 24, also the SWI marker
                logic [23:0] imm24;
        } br_fields_t;

        typedef union packed {
                dp_fields_t dp;
                br_fields_t br;
        } insn_u;

        typedef enum logic [2:0] {
                CLS_DP_IMM,
                CLS_DP_ISS,
                CLS_DP_RSS,
                CLS_BRANCH,
                CLS_SWI,
                CLS_MRS,
                CLS_MSR,
                CLS_UNDEF
        } insn_class_e;

        // ------------------------------------------------------------
        // Stage payloads
        // ------------------------------------------------------------
        typedef struct packed {
                insn_class_e cls;
                logic [3:0]  cond;
                logic [3:0]  opcode;
                logic [3:0]  rd;
                logic [3:0]  rn;
                logic [3:0]  rm;
                logic [3:0]  rs;
                logic [1:0]  sh_type;
                logic [4:0]  sh_amt;
                logic [7:0]  imm8;
                logic [3:0]  rot;
                logic        link;
                logic        spsr;              // PSR select, SPSR when set
                logic [23:0] imm24;
        } decoded_t;

        typedef logic [0:TEXT_CHARS-1][7:0] text_t;

        typedef struct packed {
                logic [0:TOKEN_CHARS-1][7:0] chars;     // Left-justified
                logic [2:0]                  len;
        } token_t;

        typedef struct packed {
                insn_class_e cls;
                token_t      mnem;
                token_t      rd;
                token_t      rn;
                token_t      rm;
                token_t      rs;
                token_t      shift;             // PSR name for MRS and MSR
                token_t      hex2;
                token_t      hex1;
                token_t      hex6;
        } tokens_t;

        // Punctuation pieces
        localparam token_t TOK_NONE    = '{chars: "      ", len: 3'd0};
        localparam token_t TOK_SP      = '{chars: "      ", len: 3'd1};
        localparam token_t TOK_COMMA   = '{chars: ",     ", len: 3'd1};
        localparam token_t TOK_HASH    = '{chars: "#     ", len: 3'd1};
        localparam token_t TOK_SP_HASH = '{chars: " #    ", len: 3'd2};
        localparam token_t TOK_ROR     = '{chars: " ROR  ", len: 3'd5};

        localparam text_t BLANK_LINE = {TEXT_CHARS{8'h20}};

endpackage

`default_nettype wire

// File: rtl/dasm_result.sv
// Result stage; one cycle, packs tokens left-justified into a space padded 32-character line
`timescale 1ns/1ps
`default_nettype none

module dasm_result (
        input  wire logic              i_clk,
        input  wire logic              i_arst_n,
        input  wire logic              i_valid,
        input  wire dasm_pkg::tokens_t i_tok,
        output      logic              o_valid,
        output      dasm_pkg::text_t   o_text
);

        dasm_pkg::token_t seq [dasm_pkg::SEQ_TOKENS];
        dasm_pkg::text_t  line;
        logic [6:0]       off;                  // Running character offset

        // ------------------------------------------------------------
        // Token order per line format
        // ------------------------------------------------------------
        always_comb
        begin
                seq = '{default: dasm_pkg::TOK_NONE};
                case (i_tok.cls)
                dasm_pkg::CLS_DP_IMM:
                        seq = '{i_tok.mnem, dasm_pkg::TOK_SP, i_tok.rd, dasm_pkg::TOK_COMMA,
                                i_tok.rn, dasm_pkg::TOK_COMMA, dasm_pkg::TOK_HASH, i_tok.hex2,
                                dasm_pkg::TOK_ROR, i_tok.hex1, dasm_pkg::TOK_NONE};
                dasm_pkg::CLS_DP_ISS:
                        seq = '{i_tok.mnem, dasm_pkg::TOK_SP, i_tok.rd, dasm_pkg::TOK_COMMA,
                                i_tok.rn, dasm_pkg::TOK_COMMA, i_tok.rm, dasm_pkg::TOK_COMMA,
                                i_tok.shift, dasm_pkg::TOK_SP_HASH, i_tok.hex2};
                dasm_pkg::CLS_DP_RSS:
                        seq = '{i_tok.mnem, dasm_pkg::TOK_SP, i_tok.rd, dasm_pkg::TOK_COMMA,
                                i_tok.rn, dasm_pkg::TOK_COMMA, i_tok.rm, dasm_pkg::TOK_COMMA,
                                i_tok.shift, dasm_pkg::TOK_SP, i_tok.rs};
                dasm_pkg::CLS_BRANCH, dasm_pkg::CLS_SWI:
                begin
                        seq[0] = i_tok.mnem;
                        seq[1] = dasm_pkg::TOK_SP_HASH;
                        seq[2] = i_tok.hex6;
                end
                dasm_pkg::CLS_MRS:
                begin
                        seq[0] = i_tok.mnem;
                        seq[1] = dasm_pkg::TOK_SP;
                        seq[2] = i_tok.rd;
                        seq[3] = dasm_pkg::TOK_COMMA;
                        seq[4] = i_tok.shift;   // CPSR or SPSR
                end
                dasm_pkg::CLS_MSR:
                begin
                        seq[0] = i_tok.mnem;
                        seq[1] = dasm_pkg::TOK_SP;
                        seq[2] = i_tok.shift;
                        seq[3] = dasm_pkg::TOK_COMMA;
                        seq[4] = i_tok.rm;
                end
                default: ;                      // UNDEF, written below
                endcase
        end

        // ------------------------------------------------------------
        // Append at running offset, rest stays blank
        // ------------------------------------------------------------
        always_comb
        begin
                line = dasm_pkg::BLANK_LINE;
                off  = 7'd0;
                for (int k = 0; k < dasm_pkg::SEQ_TOKENS; k++)
                begin
                        for (int j = 0; j < dasm_pkg::TOKEN_CHARS; j++)
                        begin
                                if (j < seq[k].len && int'(off) + j < dasm_pkg::TEXT_CHARS)
                                        line[int'(off) + j] = seq[k].chars[j];
                        end
                        off = off + 7'(seq[k].len);
                end
                if (i_tok.cls == dasm_pkg::CLS_UNDEF)
                        line[0:8] = "UNDEFINED";
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        o_valid <= 1'b0;
                        o_text  <= dasm_pkg::BLANK_LINE;
                end
                else
                begin
                        o_valid <= i_valid;
                        o_text  <= line;
                end
        end

        // Token lengths from execute must leave every format inside the line
        a_fits: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_valid |-> (off <= 7'(dasm_pkg::TEXT_CHARS)));

endmodule

`default_nettype wire

// File: rtl/dasm_top.sv
// Disassembler top; fixed 3-cycle latency, one word per clock, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module dasm_top (
        input  wire logic                         i_clk,
        input  wire logic                         i_arst_n,
        input  wire logic                         i_valid,
        input  wire logic [dasm_pkg::INSN_BITS-1:0] i_instruction,
        output      logic                         o_valid,
        output      dasm_pkg::text_t              o_text
);

        logic               dec_valid;
        dasm_pkg::decoded_t dec;
        logic               exe_valid;
        dasm_pkg::tokens_t  tok;

        dasm_decode u_decode (
                .i_clk         (i_clk),
                .i_arst_n      (i_arst_n),
                .i_valid       (i_valid),
                .i_instruction (dasm_pkg::insn_u'(i_instruction)),
                .o_valid       (dec_valid),
                .o_dec         (dec)
        );

        dasm_execute u_execute (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_valid  (dec_valid),
                .i_dec    (dec),
                .o_valid  (exe_valid),
                .o_tok    (tok)
        );

        dasm_result u_result (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_valid  (exe_valid),
                .i_tok    (tok),
                .o_valid  (o_valid),
                .o_text   (o_text)
        );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the disassembler testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_dasm -f flist.f -o sim_dasm
./obj_dir/sim_dasm > sim.log 2>&1
cat sim.log
if grep -q "^Done: no errors$" sim.log
then
        echo "PASS"
else
        echo "FAIL"
        exit 1
fi

// File: tests/tb_dasm_ref.svh
// Reference line builder, included inside the testbench module; hex digits come out uppercase
`ifndef TB_DASM_REF_SVH
`define TB_DASM_REF_SVH

        // Printed register name, 13..15 use their aliases
        function automatic string reg_name(input logic [3:0] r);
                case (r)
                4'd13:   return "SP";
                4'd14:   return "LR";
                4'd15:   return "PC";
                default: return $sformatf("R%0d", r);
                endcase
        endfunction

        // Expected 32-character line for one instruction word
        function automatic dasm_pkg::text_t dasm_ref(input logic [31:0] w);
                string           conds;
                string           ops;
                string           shifts;
                string           cc;
                string           op;
                string           sh;
                string           psr;
                string           mn;
                string           s;
                logic            dp_form;
                dasm_pkg::text_t t;

                conds  = "EQNECSCCMIPLVSVCHILSGELTGTLEALNV";
                ops    = "ANDEORSUBRSBADDADCSBCRSCTSTTEQCMPCMNORRMOVBICMVN";
                shifts = "LSLLSRASRROR";
                cc     = conds.substr(2 * int'(w[31:28]), 2 * int'(w[31:28]) + 1);
                op     = ops.substr(3 * int'(w[24:21]), 3 * int'(w[24:21]) + 2);
                sh     = shifts.substr(3 * int'(w[6:5]), 3 * int'(w[6:5]) + 2);
                psr    = w[22] ? "SPSR" : "CPSR";
                if (w[24])
                        mn = "BL";
                else
                        mn = "B";

                // Compare opcodes without S fall outside data processing
                dp_form = !(w[24:23] == 2'b10 && !w[20]);

                if (w[27:23] == 5'b00010 && w[21:16] == 6'b001111 && w[11:0] == 12'h000)
                        s = $sformatf("MRS%s %s,%s", cc, reg_name(w[15:12]), psr);
                else if (w[27:23] == 5'b00010 && w[21:20] == 2'b10 && w[15:4] == 12'hF00)
                        s = $sformatf("MSR%s %s,%s", cc, psr, reg_name(w[3:0]));
                else if (w[27:24] == 4'hF)
                        s = $sformatf("SWI%s #%h", cc, w[23:0]);
                else if (w[27:25] == 3'b101)
                        s = $sformatf("%s%s #%h", mn, cc, w[23:0]);
                else if (dp_form && w[27:25] == 3'b001)
                        s = $sformatf("%s%s %s,%s,#%h ROR %h", op, cc, reg_name(w[15:12]),
                                      reg_name(w[19:16]), w[7:0], w[11:8]);
                else if (dp_form && w[27:25] == 3'b000 && !w[4])
                        s = $sformatf("%s%s %s,%s,%s,%s #%h", op, cc, reg_name(w[15:12]),
                                      reg_name(w[19:16]), reg_name(w[3:0]), sh,
                                      {3'b000, w[11:7]});
                else if (dp_form && w[27:25] == 3'b000 && !w[7])
                        s = $sformatf("%s%s %s,%s,%s,%s %s", op, cc, reg_name(w[15:12]),
                                      reg_name(w[19:16]), reg_name(w[3:0]), sh,
                                      reg_name(w[11:8]));
                else
                        s = "UNDEFINED";

                s = s.toupper();        // Hex digits print lower case by default

                t = {dasm_pkg::TEXT_CHARS{8'h20}};
                for (int i = 0; i < s.len() && i < dasm_pkg::TEXT_CHARS; i++)
                begin
                        t[i] = s.getc(i);
                end
                return t;
        endfunction

`endif

// File: tests/tb_dasm.sv
// Self-checking testbench for dasm_top; assumes fixed 3-cycle latency and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_dasm;

        `include "tb_dasm_ref.svh"

        localparam int N_RANDOM     = 300;
        localparam int RESET_CYCLES = 16;

        logic              clk = 1'b0;
        logic              i_arst_n;
        logic              i_valid;
        logic [31:0]       i_instruction;
        logic              o_valid;
        dasm_pkg::text_t   o_text;

        logic [31:0]       dir_words [$];
        dasm_pkg::text_t   exp_q [$];   // Expected lines in issue order
        logic [31:0]       word_q [$];
        dasm_pkg::text_t   exp_line;
        logic [31:0]       exp_word;
        int                errors = 0;
        int                checks = 0;
        int                cycles = 0;
        int                limit;
        integer            seed;
        int                gap;

        always #2 clk = ~clk;           // 4 ns period

        dasm_top u_dasm_top (
                .i_clk         (clk),
                .i_arst_n      (i_arst_n),
                .i_valid       (i_valid),
                .i_instruction (i_instruction),
                .o_valid       (o_valid),
                .o_text        (o_text)
        );

        // ------------------------------------------------------------
        // Stimulus helpers
        // ------------------------------------------------------------
        task automatic send_word(input logic [31:0] w);
                @(posedge clk);
                i_valid       <= 1'b1;
                i_instruction <= w;
                exp_q.push_back(dasm_ref(w));
                word_q.push_back(w);
        endtask

        task automatic idle(input int n);
                repeat (n)
                begin
                        @(posedge clk);
                        i_valid <= 1'b0;
                end
        endtask

        task automatic load_directed();
                dir_words.push_back(32'h0281_24FF);     // ADDEQ imm
                dir_words.push_back(32'hE1A0_3284);     // MOVAL, LSL #5
                dir_words.push_back(32'h1045_6758);     // SUBNE, ASR by R7
                dir_words.push_back(32'hEB12_3456);     // BL
                dir_words.push_back(32'h0A00_00FF);     // BEQ
                dir_words.push_back(32'hEF00_ABCD);     // SWI
                dir_words.push_back(32'hE14F_D000);     // MRS SPSR
                dir_words.push_back(32'hE10F_0000);
                dir_words.push_back(32'hE129_F00E);     // MSR CPSR
                dir_words.push_back(32'h1169_F00C);
                dir_words.push_back(32'hE591_0000);     // LDR
                dir_words.push_back(32'hE89D_000F);     // LDM
                dir_words.push_back(32'hE000_0291);     // MUL
                dir_words.push_back(32'hEE01_0F10);     // MCR
                dir_words.push_back(32'hE101_0002);     // TST, S clear
                dir_words.push_back(32'hE32F_F001);     // MSR immediate
                dir_words.push_back(32'hE12F_FF1E);     // BX
                for (int c = 0; c < 16; c++)
                begin
                        dir_words.push_back({c[3:0], 28'h081_2003});
                end
                for (int op = 0; op < 16; op++)
                begin
                        dir_words.push_back({7'b1110_001, op[3:0], 1'b1, 20'h34_A5C});
                end
        endtask

        // ------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------
        initial
        begin
                i_arst_n      = 1'b0;
                i_valid       = 1'b0;
                i_instruction = 32'h0;
                seed          = 69;
                load_directed();
                limit = (dir_words.size() + N_RANDOM + 3 + RESET_CYCLES) * 2;

                // Output state while reset is still held
                repeat (RESET_CYCLES - 1) @(posedge clk);
                @(negedge clk);
                checks++;
                if (o_valid !== 1'b0)
                begin
                        errors++;
                        $display("** Error: o_valid = %h during reset, expected 0", o_valid);
                end
                checks++;
                if (o_text !== dasm_pkg::BLANK_LINE)
                begin
                        errors++;
                        $display("** Error: o_text = %h during reset, expected %h",
                                 o_text, dasm_pkg::BLANK_LINE);
                end
                @(posedge clk);
                i_arst_n <= 1'b1;
                idle(2);

                // Bursts of five back to back, then a gap
                for (int i = 0; i < dir_words.size(); i++)
                begin
                        send_word(dir_words[i]);
                        if (i % 5 == 4)
                                idle(3);
                end
                idle(1);

                for (int i = 0; i < N_RANDOM; i++)
                begin
                        send_word($random(seed));
                        gap = $random(seed) & 1;
                        idle(gap);
                end
                idle(1);

                for (int i = 0; i < 8 && exp_q.size() != 0; i++)
                begin
                        @(posedge clk);
                end
                repeat (4) @(posedge clk);      // Room for stray outputs
                if (exp_q.size() != 0)
                begin
                        errors++;
                        $display("%0d expected lines never appeared on the output", exp_q.size());
                end

                $display("Checks: %0d  Errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

        // Pop and compare on each falling edge with o_valid high
        always @(negedge clk)
        begin
                if (o_valid)
                begin
                        if (exp_q.size() == 0)
                        begin
                                errors++;
                                $display("o_valid went high with no instruction pending at %0t",
                                         $time);
                        end
                        else
                        begin
                                exp_line = exp_q.pop_front();
                                exp_word = word_q.pop_front();
                                checks++;
                                if (o_text !== exp_line)
                                begin
                                        errors++;
                                        $display("** Error: o_text = %h, expected %h (word %h)",
                                                 o_text, exp_line, exp_word);
                                end
                        end
                end
        end

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= limit)
                begin
                        $display("Timeout: run did not finish within %0d cycles", limit);
                        $display("Done: errors found");
                        $finish;
                end
        end

endmodule

`default_nettype wire
